/* hdl/canister_line_pkg.sv */
`default_nettype none

package canister_line_pkg;

    // Line constants.
    localparam logic [7:0] PRESSURE_LIMIT    = 8'd200;
    localparam logic [7:0] SPEED_MAX         = 8'd255;
    localparam logic [7:0] INJECTOR_EXTENDED = 8'd255;

    // Supervisor register map, byte addresses.
    localparam logic [3:0] REG_CONTROL    = 4'h0;
    localparam logic [3:0] REG_ACTUATORS  = 4'h4;
    localparam logic [3:0] REG_PRODUCTION = 4'h8;
    localparam logic [3:0] REG_NOTICES    = 4'hc;

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    typedef struct packed {
        logic door_site;
        logic inject_site;
        logic reject_site;
        logic reject_bin;
        logic accept_bin;
    } laser_set_t;

    typedef struct packed {
        logic       emergency_stop;
        logic [7:0] canister_pressure;
        logic [7:0] fill_available;
        laser_set_t lasers;
    } sensor_t;

    typedef struct packed {
        logic arm_finished;
        logic emergency_changed;
        logic pressure_changed;
        logic fill_changed;
        logic lasers_changed;
        logic door_override;
        logic vacuum_elapsed;
    } line_event_t;

    typedef struct packed {
        logic [7:0] conveyor_speed;
        logic [7:0] injector_position;
        logic       valve_open;
        logic       vacuum_run;
        logic       pump_run;
        logic [7:0] fill_contents;
        logic [7:0] canister_count;
    } actuator_t;

    // Declared from the top bit down, so door_release lands on bit 0.
    typedef struct packed {
        logic inject_done;
        logic canister_count_changed;
        logic go_reject_arm;
        logic start_vacuum_timer;
        logic fill_contents_changed;
        logic injector_controls_changed;
        logic injector_position_changed;
        logic conveyor_changed;
        logic door_release;
    } notice_t;

    typedef struct packed {
        logic        awvalid;
        logic [3:0]  awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        bready;
        logic        arvalid;
        logic [3:0]  araddr;
        logic        rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_rsp_t;

endpackage

`default_nettype wire

/* hdl/sensor_event_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module sensor_event_decoder (
    input  logic                           clk,
    input  logic                           reset,
    input  canister_line_pkg::sensor_t     sensors,
    input  logic                           arm_finished,
    input  logic                           vacuum_elapsed,
    input  logic                           door_override,
    output canister_line_pkg::sensor_t     sensed,
    output canister_line_pkg::line_event_t events
);
    import canister_line_pkg::*;

    line_event_t next_events;
    logic        stop_differs;
    logic        pressure_differs;
    logic        fill_differs;
    logic        lasers_differ;

    // The registered sample is the previous value of the raw inputs, so comparing
    // against it flags a change in the same cycle the new value is captured.
    assign stop_differs     = sensors.emergency_stop != sensed.emergency_stop;
    assign pressure_differs = sensors.canister_pressure != sensed.canister_pressure;
    assign fill_differs     = sensors.fill_available != sensed.fill_available;
    assign lasers_differ    = sensors.lasers != sensed.lasers; // Any laser bit.

    always_comb begin
        next_events.arm_finished      = arm_finished;
        next_events.emergency_changed = stop_differs;
        next_events.pressure_changed  = pressure_differs;
        next_events.fill_changed      = fill_differs;
        next_events.lasers_changed    = lasers_differ;
        next_events.door_override     = door_override;
        next_events.vacuum_elapsed    = vacuum_elapsed;
    end

    // One cycle of latency for every input, sensors and strobes alike.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sensed <= '0;
            events <= '0;
        end else begin
            sensed <= sensors;
            events <= next_events; // Each event lives for exactly one cycle.
        end
    end

endmodule

`default_nettype wire

/* hdl/manufacturing_process_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module manufacturing_process_controller (
    input  logic                           clk,
    input  logic                           reset,
    input  canister_line_pkg::sensor_t     sensed,
    input  canister_line_pkg::line_event_t events,
    output canister_line_pkg::actuator_t   actuators,
    output canister_line_pkg::notice_t     notices
);
    import canister_line_pkg::*;

    logic pressure_high;
    logic speed_at_max;
    logic door_and_reject;

    assign pressure_high   = sensed.canister_pressure > PRESSURE_LIMIT;
    assign speed_at_max    = actuators.conveyor_speed == SPEED_MAX;
    assign door_and_reject = sensed.lasers.door_site && sensed.lasers.reject_site;

    // The order of the checks below matters. Later rules override earlier ones,
    // which is how arm_finished beats vacuum_elapsed in the same cycle.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            actuators <= '0;
            notices   <= '0;
        end else begin
            notices <= '0; // Notices are pulses.

            if (events.emergency_changed && sensed.emergency_stop) begin
                actuators.conveyor_speed <= '0;
                actuators.vacuum_run     <= 1'b0;
                actuators.pump_run       <= 1'b0;
            end

            // No speed-up while the stop is held, and the speed saturates.
            if (events.pressure_changed && pressure_high && !sensed.emergency_stop) begin
                if (!speed_at_max) begin
                    actuators.conveyor_speed <= actuators.conveyor_speed + 8'd1;
                    notices.conveyor_changed <= 1'b1;
                end
            end

            if (events.fill_changed) begin
                actuators.fill_contents       <= sensed.fill_available;
                notices.fill_contents_changed <= 1'b1;
            end

            if (events.lasers_changed) begin
                if (door_and_reject) begin
                    notices.door_release <= 1'b1;
                end
                if (sensed.lasers.inject_site) begin
                    actuators.injector_position       <= INJECTOR_EXTENDED;
                    notices.injector_position_changed <= 1'b1;
                end
                if (sensed.lasers.reject_bin) begin
                    notices.go_reject_arm <= 1'b1; // Only the command, no arm here.
                end
                if (sensed.lasers.accept_bin) begin
                    // Wraps from 255 back to 0.
                    actuators.canister_count       <= actuators.canister_count + 8'd1;
                    notices.canister_count_changed <= 1'b1;
                end
            end

            // End of the vacuum phase; the pump keeps running.
            if (events.vacuum_elapsed) begin
                actuators.valve_open              <= 1'b0;
                actuators.vacuum_run              <= 1'b0;
                notices.inject_done               <= 1'b1;
                notices.injector_controls_changed <= 1'b1;
            end

            if (events.arm_finished) begin
                actuators.valve_open              <= 1'b1;
                actuators.vacuum_run              <= 1'b1;
                actuators.pump_run                <= 1'b1;
                notices.start_vacuum_timer        <= 1'b1; // The timer itself is external.
                notices.injector_controls_changed <= 1'b1;
            end

            if (events.door_override) begin
                notices.door_release <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/line_status_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module line_status_regs (
    input  logic                         clk,
    input  logic                         reset,
    input  canister_line_pkg::axil_req_t axil_req,
    output canister_line_pkg::axil_rsp_t axil_rsp,
    input  canister_line_pkg::actuator_t actuators,
    input  canister_line_pkg::notice_t   notices,
    output logic                         door_override
);
    import canister_line_pkg::*;

    logic        wr_ready;
    logic        rd_ready;
    logic        bvalid;
    logic        rvalid;
    logic [31:0] rdata;
    logic        idle;
    logic        write_fire;
    logic        read_fire;
    logic [31:0] read_word;
    notice_t     clear_mask;
    notice_t     sticky;

    // Nothing new is taken while a response is still waiting.
    assign idle       = !bvalid && !rvalid;
    assign write_fire = wr_ready && axil_req.awvalid && axil_req.wvalid;
    assign read_fire  = rd_ready && axil_req.arvalid;

    // Byte lane 0 covers flags 7..0, lane 1 covers flag 8.
    always_comb begin
        clear_mask = '0;
        if (write_fire && axil_req.awaddr == REG_NOTICES) begin
            clear_mask = notice_t'({axil_req.wdata[8] & axil_req.wstrb[1],
                                    axil_req.wdata[7:0] & {8{axil_req.wstrb[0]}}});
        end
    end

    always_comb begin
        case (axil_req.araddr)
            REG_ACTUATORS:  read_word = {13'd0, actuators.pump_run, actuators.vacuum_run,
                                         actuators.valve_open, actuators.injector_position,
                                         actuators.conveyor_speed};
            REG_PRODUCTION: read_word = {16'd0, actuators.canister_count,
                                         actuators.fill_contents};
            REG_NOTICES:    read_word = {23'd0, sticky};
            default:        read_word = '0; // Control is write-only, reads as zero.
        endcase
    end

    // Write path. awready and wready rise together one cycle after the request
    // is seen; the handshake then queues bvalid and the control pulse.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ready      <= 1'b0;
            bvalid        <= 1'b0;
            door_override <= 1'b0;
        end else begin
            wr_ready      <= !wr_ready && idle && axil_req.awvalid && axil_req.wvalid;
            door_override <= write_fire && axil_req.awaddr == REG_CONTROL &&
                             axil_req.wstrb[0] && axil_req.wdata[0];
            if (write_fire) begin
                bvalid <= 1'b1;
            end else if (axil_req.bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_ready <= 1'b0;
            rvalid   <= 1'b0;
            rdata    <= '0;
        end else begin
            rd_ready <= !rd_ready && idle && axil_req.arvalid;
            if (read_fire) begin
                rvalid <= 1'b1;
                rdata  <= read_word;
            end else if (axil_req.rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // A notice pulse in the same cycle as a clear keeps its flag set.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sticky <= '0;
        end else begin
            sticky <= (sticky & ~clear_mask) | notices;
        end
    end

    always_comb begin
        axil_rsp.awready = wr_ready;
        axil_rsp.wready  = wr_ready;
        axil_rsp.bvalid  = bvalid;
        axil_rsp.bresp   = AXI_RESP_OKAY;
        axil_rsp.arready = rd_ready;
        axil_rsp.rvalid  = rvalid;
        axil_rsp.rdata   = rdata;
        axil_rsp.rresp   = AXI_RESP_OKAY;
    end

endmodule

`default_nettype wire

/* hdl/canister_line_top.sv */
`timescale 1ns/1ps
`default_nettype none

module canister_line_top (
    input  logic                         clk,
    input  logic                         reset,
    input  canister_line_pkg::sensor_t   sensors,
    input  logic                         arm_finished,
    input  logic                         vacuum_elapsed,
    input  canister_line_pkg::axil_req_t axil_req,
    output canister_line_pkg::axil_rsp_t axil_rsp,
    output canister_line_pkg::actuator_t actuators,
    output canister_line_pkg::notice_t   notices
);
    import canister_line_pkg::*;

    sensor_t     sensed;
    line_event_t events;
    logic        door_override;

    // Decode stage.
    sensor_event_decoder u_decoder (
        .clk            (clk),
        .reset          (reset),
        .sensors        (sensors),
        .arm_finished   (arm_finished),
        .vacuum_elapsed (vacuum_elapsed),
        .door_override  (door_override),
        .sensed         (sensed),
        .events         (events)
    );

    // Execute stage.
    manufacturing_process_controller u_controller (
        .clk       (clk),
        .reset     (reset),
        .sensed    (sensed),
        .events    (events),
        .actuators (actuators),
        .notices   (notices)
    );

    // Result stage, the supervisor's view of the line.
    line_status_regs u_regs (
        .clk           (clk),
        .reset         (reset),
        .axil_req      (axil_req),
        .axil_rsp      (axil_rsp),
        .actuators     (actuators),
        .notices       (notices),
        .door_override (door_override) // Loops back into the decoder.
    );

endmodule

`default_nettype wire

/* testbench/canister_line_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module canister_line_checker (
    input logic                           clk,
    input logic                           reset,
    input canister_line_pkg::axil_req_t   axil_req,
    input canister_line_pkg::axil_rsp_t   axil_rsp,
    input canister_line_pkg::line_event_t events,
    input canister_line_pkg::actuator_t   actuators,
    input canister_line_pkg::notice_t     notices
);

    // A notice only follows an event one cycle earlier, so without events it drops.
    notice_pulse: assert property (@(posedge clk) disable iff (reset)
        notices != '0 |-> $past(events) != '0)
        else $error("a notice bit was high without an event before it");

    bvalid_hold: assert property (@(posedge clk) disable iff (reset)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
        else $error("bvalid dropped before bready");

    rvalid_hold: assert property (@(posedge clk) disable iff (reset)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid)
        else $error("rvalid dropped before rready");

    reset_quiet: assert property (@(posedge clk)
        reset && $past(reset) |-> actuators == '0 && notices == '0 &&
        !axil_rsp.awready && !axil_rsp.wready && !axil_rsp.bvalid &&
        !axil_rsp.arready && !axil_rsp.rvalid)
        else $error("outputs not quiet during reset");

endmodule

bind canister_line_top canister_line_checker u_checker (
    .clk       (clk),
    .reset     (reset),
    .axil_req  (axil_req),
    .axil_rsp  (axil_rsp),
    .events    (events),
    .actuators (actuators),
    .notices   (notices)
);

`default_nettype wire

/* testbench/canister_line_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module canister_line_tb;
    import canister_line_pkg::*;

    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 8;
    localparam int SETTLE_CYCLES  = 2;    // Sensor change to actuator output.
    localparam int TIMEOUT_CYCLES = 2000; // The tests take roughly 700 cycles.

    logic      clk;
    logic      reset;
    sensor_t   sensors;
    logic      arm_finished;
    logic      vacuum_elapsed;
    axil_req_t axil_req;
    axil_rsp_t axil_rsp;
    actuator_t actuators;
    notice_t   notices;

    int         cycle_count;
    int         notice_edge [9]; // Last edge that raised each notice bit.
    int         handshake_edge;
    int         accept_events;
    logic [7:0] exp_speed;

    canister_line_top u_dut (
        .clk            (clk),
        .reset          (reset),
        .sensors        (sensors),
        .arm_finished   (arm_finished),
        .vacuum_elapsed (vacuum_elapsed),
        .axil_req       (axil_req),
        .axil_rsp       (axil_rsp),
        .actuators      (actuators),
        .notices        (notices)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        for (int i = 0; i < 9; i++) begin
            if (notices[i]) begin
                notice_edge[i] <= cycle_count;
            end
        end
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped responding", TIMEOUT_CYCLES);
            $display("TEST RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            $display("MISMATCH at time %0t: %s is 0x%0h, expected 0x%0h",
                     $time, what, got, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic axil_write(input logic [3:0] addr, input logic [31:0] data, input int hold);
        @(negedge clk);
        axil_req.awvalid = 1'b1;
        axil_req.awaddr  = addr;
        axil_req.wvalid  = 1'b1;
        axil_req.wdata   = data;
        axil_req.wstrb   = 4'hf;
        do begin
            @(negedge clk);
        end while (!axil_rsp.awready);
        handshake_edge = cycle_count;
        check_value("wready with awready", 32'(axil_rsp.wready), 32'd1);
        @(negedge clk);
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        check_value("bvalid after write", 32'(axil_rsp.bvalid), 32'd1);
        repeat (hold) begin
            @(negedge clk);
            check_value("bvalid while bready is low", 32'(axil_rsp.bvalid), 32'd1);
        end
        check_value("bresp", 32'(axil_rsp.bresp), 32'd0);
        axil_req.bready = 1'b1;
        @(negedge clk);
        axil_req.bready = 1'b0;
    endtask

    task automatic axil_read(input logic [3:0] addr, input int hold, output logic [31:0] data);
        @(negedge clk);
        axil_req.arvalid = 1'b1;
        axil_req.araddr  = addr;
        do begin
            @(negedge clk);
        end while (!axil_rsp.arready);
        @(negedge clk);
        axil_req.arvalid = 1'b0;
        check_value("rvalid after read", 32'(axil_rsp.rvalid), 32'd1);
        repeat (hold) begin
            @(negedge clk);
            check_value("rvalid while rready is low", 32'(axil_rsp.rvalid), 32'd1);
        end
        check_value("rresp", 32'(axil_rsp.rresp), 32'd0);
        data            = axil_rsp.rdata;
        axil_req.rready = 1'b1;
        @(negedge clk);
        axil_req.rready = 1'b0;
    endtask

    task automatic read_check(input logic [3:0] addr, input logic [31:0] expected,
                              input string what);
        logic [31:0] word;
        axil_read(addr, 0, word);
        check_value(what, word, expected);
    endtask

    task automatic settle();
        repeat (SETTLE_CYCLES) @(negedge clk);
    endtask

    // A pulse counts only if it was raised after the edge given in start.
    task automatic wait_notice(input int index, input int start);
        while (notice_edge[index] <= start) begin
            @(negedge clk);
        end
    endtask

    task automatic drive_sensors(input sensor_t value);
        @(negedge clk);
        sensors = value;
    endtask

    function automatic logic [7:0] new_pressure(input logic high, input logic [7:0] current);
        logic [7:0] value;
        do begin
            value = high ? 8'($urandom_range(255, 201)) : 8'($urandom_range(200, 0));
        end while (value == current); // Only a change makes an event.
        return value;
    endfunction

    task automatic pressure_step(input logic high);
        sensor_t sample;
        sample = sensors;
        sample.canister_pressure = new_pressure(high, sensors.canister_pressure);
        if (sample.canister_pressure > PRESSURE_LIMIT && !sample.emergency_stop &&
            exp_speed != SPEED_MAX) begin
            exp_speed = exp_speed + 8'd1;
        end
        drive_sensors(sample);
    endtask

    // Laser bits from the top: door, inject, reject site, reject bin, accept bin.
    task automatic drive_lasers(input laser_set_t pattern);
        sensor_t sample;
        sample = sensors;
        if (pattern != sensors.lasers && pattern.accept_bin) begin
            accept_events++;
        end
        sample.lasers = pattern;
        drive_sensors(sample);
    endtask

    task automatic pulse_strobe(input logic vacuum, input int notice_bit);
        int start;
        start = cycle_count;
        @(negedge clk);
        arm_finished   = !vacuum;
        vacuum_elapsed = vacuum;
        @(negedge clk);
        arm_finished   = 1'b0;
        vacuum_elapsed = 1'b0;
        wait_notice(notice_bit, start);
    endtask

    task automatic test_reset_readback();
        check_value("actuators after reset", 32'(|actuators), 32'd0);
        check_value("notices after reset", 32'(|notices), 32'd0);
        read_check(REG_ACTUATORS, 32'd0, "REG_ACTUATORS after reset");
        read_check(REG_PRODUCTION, 32'd0, "REG_PRODUCTION after reset");
        read_check(REG_NOTICES, 32'd0, "REG_NOTICES after reset");
    endtask

    task automatic test_pressure_and_stop();
        sensor_t sample;
        int      start;
        repeat (3) pressure_step(1'b0);
        settle();
        check_value("speed after low pressures", 32'(actuators.conveyor_speed), 32'd0);
        read_check(REG_NOTICES, 32'd0, "flags after low pressures");
        start = cycle_count;
        for (int i = 0; i < 12; i++) begin
            pressure_step(i % 3 != 2);
        end
        wait_notice(1, start);
        settle();
        check_value("speed after mixed pressures", 32'(actuators.conveyor_speed), 32'(exp_speed));
        read_check(REG_ACTUATORS, 32'(exp_speed), "REG_ACTUATORS speed");
        read_check(REG_NOTICES, 32'h002, "conveyor_changed flag");
        repeat (260) pressure_step(1'b1);
        settle();
        read_check(REG_ACTUATORS, 32'(exp_speed), "saturated speed");
        pulse_strobe(1'b0, 5); // Pump and vacuum run, so the stop has work to do.
        axil_write(REG_NOTICES, 32'h1ff, 0);
        repeat (3) pressure_step(1'b1);
        sample = sensors;
        sample.emergency_stop = 1'b1;
        exp_speed = 8'd0;
        drive_sensors(sample);
        settle();
        check_value("speed after stop", 32'(actuators.conveyor_speed), 32'd0);
        check_value("pump and vacuum after stop",
                    32'({actuators.pump_run, actuators.vacuum_run}), 32'd0);
        repeat (4) pressure_step(1'b1);
        settle();
        check_value("speed during stop", 32'(actuators.conveyor_speed), 32'd0);
        read_check(REG_NOTICES, 32'd0, "flags after saturation and stop");
        sample = sensors;
        sample.emergency_stop = 1'b0;
        drive_sensors(sample);
        settle();
        check_value("speed after stop release", 32'(actuators.conveyor_speed), 32'd0);
    endtask

    task automatic test_fill_and_lasers();
        sensor_t    sample;
        int         start;
        logic [7:0] fill;
        fill = 8'($urandom_range(255, 1));
        sample = sensors;
        sample.fill_available = fill;
        start = cycle_count;
        drive_sensors(sample);
        wait_notice(4, start);
        read_check(REG_PRODUCTION, {16'd0, 8'd0, fill}, "fill contents");
        start = cycle_count;
        drive_lasers(laser_set_t'(5'b10100));
        wait_notice(0, start); // Door release from door site with reject site.
        start = cycle_count;
        drive_lasers(laser_set_t'(5'b00010));
        wait_notice(6, start);
        start = cycle_count;
        drive_lasers(laser_set_t'(5'b01000));
        wait_notice(2, start);
        read_check(REG_ACTUATORS, {13'd0, 3'b001, 8'hff, exp_speed}, "injector extended");
        start = cycle_count;
        for (int i = 0; i < 260; i++) begin
            drive_lasers(laser_set_t'({2'b00, i[0], 2'b01}));
        end
        wait_notice(7, start);
        drive_lasers(laser_set_t'(5'b00000));
        settle();
        check_value("canister count", 32'(actuators.canister_count), 32'(accept_events % 256));
        read_check(REG_PRODUCTION, {16'd0, 8'(accept_events % 256), fill}, "REG_PRODUCTION");
    endtask

    task automatic test_injection_cycle();
        pulse_strobe(1'b0, 5);
        read_check(REG_ACTUATORS, {13'd0, 3'b111, 8'hff, exp_speed}, "after arm_finished");
        pulse_strobe(1'b1, 8);
        read_check(REG_ACTUATORS, {13'd0, 3'b100, 8'hff, exp_speed}, "after vacuum_elapsed");
    endtask

    task automatic test_supervisor();
        int start;
        axil_write(REG_NOTICES, 32'h1ff, 0);
        start = cycle_count;
        axil_write(REG_CONTROL, 32'h1, 0);
        wait_notice(0, start);
        // The register block, the decoder and the controller add one edge each.
        check_value("door_release edges after handshake",
                    32'(notice_edge[0] - handshake_edge), 32'd3);
        pulse_strobe(1'b0, 5);
        pulse_strobe(1'b1, 8);
        read_check(REG_NOTICES, 32'h129, "flags before clearing");
        axil_write(REG_NOTICES, 32'h021, 4);
        read_check(REG_NOTICES, 32'h108, "flags after partial clear");
        axil_write(REG_NOTICES, 32'h100, 0);
        read_check(REG_NOTICES, 32'h008, "flags after clearing bit 8");
    endtask

    initial begin
        logic [31:0] word;
        void'($urandom(32'h216a));
        reset          = 1'b1;
        sensors        = '0;
        arm_finished   = 1'b0;
        vacuum_elapsed = 1'b0;
        axil_req       = '0;
        exp_speed      = 8'd0;
        accept_events  = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        test_reset_readback();
        test_pressure_and_stop();
        test_fill_and_lasers();
        test_injection_cycle();
        test_supervisor();
        axil_read(REG_CONTROL, 3, word); // Held rready, and a write-only register.
        check_value("REG_CONTROL read", word, 32'd0);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
hdl/canister_line_pkg.sv
hdl/sensor_event_decoder.sv
hdl/manufacturing_process_controller.sv
hdl/line_status_regs.sv
hdl/canister_line_top.sv
testbench/canister_line_checker.sv
testbench/canister_line_tb.sv

/* Makefile */
TOP = canister_line_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --assert --timescale 1ns/1ps --top-module $(TOP) \
		-f verilog.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
